/* filelist.f */
sd_spi_pkg.sv
sd_card_pkg.sv
sd_cmd_decoder.sv
sd_reply_fifo.sv
sd_spi_tx.sv
sd_card.sv
tb_sd_card_properties.sv
tb_sd_card.sv

/* Bender.yml */
package:
  name: sd_card

sources:
  - sd_spi_pkg.sv
  - sd_card_pkg.sv
  - sd_cmd_decoder.sv
  - sd_reply_fifo.sv
  - sd_spi_tx.sv
  - sd_card.sv
  - target: test
    files:
      - tb_sd_card_properties.sv
      - tb_sd_card.sv

/* tb_sd_card.sv */
/*
 * Testbench for the SPI mode SD card emulation.
 * An SPI master plays a table of commands into the card and checks the
 * R1 reply, the extra reply bytes and, for block reads, the token, the
 * 512 sector bytes and the CRC filler. A model of the IO controller
 * feeds the sector data under the io_din_ready handshake.
 */
`default_nettype none

module tb_sd_card;

	timeunit 1ns;
	timeprecision 1ps;

	// one table row per command
	typedef struct packed {
		logic [7:0]  cmd;
		logic [31:0] arg;
		logic        sdhc;
		logic [7:0]  r1;
		logic [2:0]  n_extra;
		logic [31:0] extra;
		logic        rd;
		logic [7:0]  half_sck;
	} row_t;

	localparam int num_rows = 13;

	logic        buffer_dout_strobe = 1'b0;
	logic        io_ack;
	logic        sd_cs;
	logic        sd_sck;
	logic        sd_sdi;
	logic        allow_sdhc;
	logic [7:0]  io_din;
	logic        io_din_strobe;
	wire         sd_sdo;
	wire         io_rd;
	wire  [31:0] io_lba;
	wire         io_din_ready;

	row_t        rows [num_rows];
	logic        table_ready = 1'b0;
	// written by the IO controller model only
	logic [31:0] lba_seen = '0;
	int          read_count = 0;

	sd_card sd_card_inst (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.sd_cs              (sd_cs),
		.sd_sck             (sd_sck),
		.sd_sdi             (sd_sdi),
		.allow_sdhc         (allow_sdhc),
		.io_din             (io_din),
		.io_din_strobe      (io_din_strobe),
		.sd_sdo             (sd_sdo),
		.io_rd              (io_rd),
		.io_lba             (io_lba),
		.io_din_ready       (io_din_ready)
	);

	// 8 ns system clock
	always #4 buffer_dout_strobe = ~buffer_dout_strobe;

	// lands 1 ns after a rising edge
	task automatic wait_clocks(input int n);
		repeat (n) @(posedge buffer_dout_strobe);
		#1;
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// one full duplex byte, mode 0, MSB first
	task automatic spi_byte(input logic [7:0] tx, input int half, output logic [7:0] rx);
		for (int b = 7; b >= 0; b--) begin
			sd_sdi = tx[b];
			wait_clocks(half);
			sd_sck = 1'b1;
			// sdo settled since the previous fall
			rx[b] = sd_sdo;
			wait_clocks(half);
			sd_sck = 1'b0;
		end
	endtask

	// cmd, arg, sdhc, r1, extra count, extra bytes, read, sck half period
	task automatic load_table();
		rows[0]  = '{8'h40, 32'h0000_0000, 1'b0, 8'h01, 3'd0, 32'h0, 1'b0, 8'd8};
		rows[1]  = '{8'h48, 32'h0000_01aa, 1'b0, 8'h01, 3'd4, 32'h0000_01aa, 1'b0, 8'd8};
		rows[2]  = '{8'h77, 32'h0000_0000, 1'b0, 8'h01, 3'd0, 32'h0, 1'b0, 8'd8};
		// ACMD41 straight after CMD55
		rows[3]  = '{8'h69, 32'h4000_0000, 1'b0, 8'h00, 3'd0, 32'h0, 1'b0, 8'd8};
		rows[4]  = '{8'h41, 32'h0000_0000, 1'b0, 8'h00, 3'd0, 32'h0, 1'b0, 8'd8};
		// CMD2 is not supported
		rows[5]  = '{8'h42, 32'h0000_0000, 1'b0, 8'h04, 3'd0, 32'h0, 1'b0, 8'd8};
		rows[6]  = '{8'h50, 32'h0000_0200, 1'b0, 8'h00, 3'd0, 32'h0, 1'b0, 8'd8};
		rows[7]  = '{8'h50, 32'h0000_0400, 1'b0, 8'h40, 3'd0, 32'h0, 1'b0, 8'd8};
		// OCR bit 30 follows allow_sdhc
		rows[8]  = '{8'h7a, 32'h0000_0000, 1'b1, 8'h00, 3'd4, 32'h4000_0000, 1'b0, 8'd8};
		rows[9]  = '{8'h7a, 32'h0000_0000, 1'b0, 8'h00, 3'd4, 32'h0000_0000, 1'b0, 8'd8};
		rows[10] = '{8'h51, 32'h0000_0123, 1'b1, 8'h00, 3'd0, 32'h0, 1'b1, 8'd8};
		rows[11] = '{8'h51, 32'h0000_0400, 1'b0, 8'h00, 3'd0, 32'h0, 1'b1, 8'd8};
		// slow master, 64 clock sck period
		rows[12] = '{8'h51, 32'h0000_1f80, 1'b1, 8'h00, 3'd0, 32'h0, 1'b1, 8'd32};
	endtask

	task automatic run_row(input int r);
		row_t        row;
		logic [7:0]  rx;
		logic [31:0] exp_lba;
		int          n;
		int          reads_before;
		row = rows[r];
		// block number for sdhc, byte offset otherwise
		exp_lba = row.sdhc ? row.arg : (row.arg >> 9);
		reads_before = read_count;
		allow_sdhc = row.sdhc;
		sd_sdi = 1'b1;
		wait_clocks(4);
		sd_cs = 1'b0;
		wait_clocks(8);
		spi_byte(row.cmd, row.half_sck, rx);
		for (int k = 3; k >= 0; k--)
			spi_byte(row.arg[8*k +: 8], row.half_sck, rx);
		// dummy CRC with end bit
		spi_byte(8'h01, row.half_sck, rx);
		// skip idle bytes up to the R1
		rx = 8'hff;
		n = 0;
		while (rx == 8'hff) begin
			if (n == 16)
				abort_run($sformatf("row %0d, no R1 reply within 16 bytes", r));
			spi_byte(8'hff, row.half_sck, rx);
			n++;
		end
		check_equal(rx, row.r1, $sformatf("row %0d R1", r));
		for (int k = 0; k < row.n_extra; k++) begin
			spi_byte(8'hff, row.half_sck, rx);
			check_equal(rx, row.extra[31 - 8*k -: 8], $sformatf("row %0d extra byte %0d", r, k));
		end
		if (row.rd) begin
			rx = 8'hff;
			n = 0;
			while (rx == 8'hff) begin
				if (n == 16)
					abort_run($sformatf("row %0d, no data token within 16 bytes", r));
				spi_byte(8'hff, row.half_sck, rx);
				n++;
			end
			check_equal(rx, 8'hfe, $sformatf("row %0d data token", r));
			check_equal(read_count, reads_before + 1, $sformatf("row %0d io_rd requests", r));
			check_equal(lba_seen, exp_lba, $sformatf("row %0d io_lba", r));
			for (int i = 0; i < 512; i++) begin
				spi_byte(8'hff, row.half_sck, rx);
				check_equal(rx, (exp_lba + 32'(i)) & 32'hff,
					$sformatf("row %0d sector byte %0d", r, i));
			end
			for (int k = 0; k < 2; k++) begin
				spi_byte(8'hff, row.half_sck, rx);
				check_equal(rx, 8'hff, $sformatf("row %0d CRC byte %0d", r, k));
			end
		end
		wait_clocks(4);
		sd_cs = 1'b1;
		wait_clocks(16);
	endtask

	// a failed bound assertion ends the run at once
	always @(sd_card_inst.props_inst.fail_count) begin
		if (sd_card_inst.props_inst.fail_count != 0)
			abort_run("a bound assertion on the card failed");
	end

	// IO controller, sector byte i is the low byte of lba + i
	initial begin : io_controller
		logic [31:0] lba;
		int          gap;
		io_din = 8'h00;
		io_din_strobe = 1'b0;
		void'($urandom(32'h6166_148a));
		forever begin
			wait_clocks(1);
			if (io_rd === 1'b1) begin
				lba = io_lba;
				lba_seen = lba;
				read_count++;
				for (int i = 0; i < 512; i++) begin
					// random idle cycles, then wait for ready
					gap = $urandom_range(0, 5);
					while (gap > 0 || io_din_ready !== 1'b1) begin
						if (gap > 0)
							gap--;
						wait_clocks(1);
					end
					io_din = 8'(lba + 32'(i));
					io_din_strobe = 1'b1;
					wait_clocks(1);
					io_din_strobe = 1'b0;
				end
			end
		end
	end

	// 600 byte times per row at that row's sck rate, plus margin
	initial begin : watchdog
		longint limit_ns;
		wait (table_ready);
		limit_ns = 2000;
		for (int r = 0; r < num_rows; r++)
			limit_ns += longint'(600) * 8 * 2 * rows[r].half_sck * 8;
		#(limit_ns);
		abort_run("watchdog expired before the command table finished");
	end

	initial begin : main
		io_ack = 1'b1;
		sd_cs = 1'b1;
		sd_sck = 1'b0;
		sd_sdi = 1'b1;
		allow_sdhc = 1'b0;
		load_table();
		table_ready = 1'b1;
		wait_clocks(16);
		io_ack = 1'b0;
		wait_clocks(4);
		// idle state out of reset
		check_equal(io_rd, 1'b0, "io_rd after reset");
		check_equal(io_din_ready, 1'b0, "io_din_ready after reset");
		check_equal(sd_sdo, 1'b1, "sd_sdo after reset");
		for (int r = 0; r < num_rows; r++)
			run_row(r);
		wait_clocks(8);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_sd_card_properties.sv */
/*
 * Assertions bound into the SD card top level.
 * Watch the decoder credit counter, the IO controller handshake and
 * the idle level of sd_sdo while the card is deselected.
 */
`default_nettype none

module tb_sd_card_properties import sd_card_pkg::*; (
	input wire          clk,
	input wire          rst,
	input wire          push,
	input wire credit_t credits,
	input wire          io_din_strobe,
	input wire          io_din_ready,
	input wire          sd_cs,
	input wire          sd_sdo
);

	timeunit 1ns;
	timeprecision 1ps;

	// number of failed assertions so far
	int fail_count = 0;

	// a push always spends a credit that exists
	a_push_credit: assert property (@(posedge clk) disable iff (rst)
		push |-> credits != '0)
	else begin
		$error("push without credit");
		fail_count++;
	end

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= credit_t'(reply_fifo_depth))
	else begin
		$error("credit count above FIFO depth");
		fail_count++;
	end

	a_strobe_ready: assert property (@(posedge clk) disable iff (rst)
		io_din_strobe |-> io_din_ready)
	else begin
		$error("io_din_strobe while io_din_ready low");
		fail_count++;
	end

	// cs goes through two sync flops before sdo is forced high
	a_sdo_idle: assert property (@(posedge clk) disable iff (rst)
		sd_cs [*4] |-> sd_sdo)
	else begin
		$error("sd_sdo low while deselected");
		fail_count++;
	end

endmodule

bind sd_card tb_sd_card_properties props_inst (
	.clk           (buffer_dout_strobe),
	.rst           (io_ack),
	.push          (push),
	.credits       (u_decoder.credits),
	.io_din_strobe (io_din_strobe),
	.io_din_ready  (io_din_ready),
	.sd_cs         (sd_cs),
	.sd_sdo        (sd_sdo)
);

`default_nettype wire

/* sd_card.sv */
/*
 * SD card emulation, SPI mode, top level.
 * Synchronises the SPI pins into the system clock, detects sck edges
 * and connects decoder, reply FIFO and transmitter. sd_sck must stay
 * at or below one eighth of the system clock.
 */
`default_nettype none

module sd_card import sd_card_pkg::*; (
	input  wire      buffer_dout_strobe,
	input  wire      io_ack,
	input  wire      sd_cs,
	input  wire      sd_sck,
	input  wire      sd_sdi,
	input  wire      allow_sdhc,
	input  sd_byte_t io_din,
	input  wire      io_din_strobe,
	output logic     sd_sdo,
	output logic     io_rd,
	output sd_lba_t  io_lba,
	output logic     io_din_ready
);

	typedef struct packed {
		logic cs;
		logic sck;
		logic sdi;
	} spi_pins_t;

	// two flop synchroniser plus sck history
	spi_pins_t pins_meta;
	spi_pins_t pins_sync;
	logic      sck_last;

	logic cs_active;
	logic sck_rise;
	logic sck_fall;
	logic sdi_bit;

	// decoder to FIFO to transmitter
	logic        push;
	reply_item_t push_item;
	logic        credit_return;
	reply_item_t head;
	logic        valid;
	logic        pop;

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			// deselected, sck low
			pins_meta <= '{cs: 1'b1, sck: 1'b0, sdi: 1'b1};
			pins_sync <= '{cs: 1'b1, sck: 1'b0, sdi: 1'b1};
			sck_last  <= 1'b0;
		end else begin
			pins_meta <= '{cs: sd_cs, sck: sd_sck, sdi: sd_sdi};
			pins_sync <= pins_meta;
			sck_last  <= pins_sync.sck;
		end
	end

	// cs is active low
	assign cs_active = !pins_sync.cs;
	assign sck_rise  = pins_sync.sck && !sck_last;
	assign sck_fall  = !pins_sync.sck && sck_last;
	// sdi travels with sck, so it is aligned with sck_rise
	assign sdi_bit   = pins_sync.sdi;

	sd_cmd_decoder u_decoder (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.cs_active          (cs_active),
		.sck_rise           (sck_rise),
		.sdi_bit            (sdi_bit),
		.allow_sdhc         (allow_sdhc),
		.io_din             (io_din),
		.io_din_strobe      (io_din_strobe),
		.credit_return      (credit_return),
		.push               (push),
		.push_item          (push_item),
		.io_rd              (io_rd),
		.io_lba             (io_lba),
		.io_din_ready       (io_din_ready)
	);

	sd_reply_fifo u_fifo (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.push               (push),
		.push_item          (push_item),
		.pop                (pop),
		.head               (head),
		.valid              (valid),
		.credit_return      (credit_return)
	);

	sd_spi_tx u_tx (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.cs_active          (cs_active),
		.sck_fall           (sck_fall),
		.head               (head),
		.valid              (valid),
		.pop                (pop),
		.sd_sdo             (sd_sdo)
	);

endmodule

`default_nettype wire

/* sd_spi_tx.sv */
/*
 * SPI transmitter, consumer of the reply FIFO.
 * A byte starts on every eighth cs-active sck falling edge and goes
 * out MSB first on sd_sdo. An empty FIFO at a byte start sends the
 * idle pattern. sd_sdo stays high while the card is deselected.
 */
`default_nettype none

module sd_spi_tx import sd_spi_pkg::*, sd_card_pkg::*; (
	input  wire         buffer_dout_strobe,
	input  wire         io_ack,
	input  wire         cs_active,
	input  wire         sck_fall,
	input  reply_item_t head,
	input  wire         valid,
	output logic        pop,
	output logic        sd_sdo
);

	logic [7:0] shifter;
	logic [2:0] bit_cnt;
	logic       byte_start;

	// the first byte after select is already on the line as idle,
	// so later bytes begin on the fall after each eighth rise
	assign byte_start = cs_active && sck_fall && (bit_cnt == 3'd7);

	// head is taken at the load only
	assign pop = byte_start && valid;

	// current bit sits at the top of the shifter
	assign sd_sdo = shifter[7];

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			shifter <= idle_byte;
			bit_cnt <= 3'd0;
		end else if (!cs_active) begin
			// deselected, line high and framing restarts
			shifter <= idle_byte;
			bit_cnt <= 3'd0;
		end else if (sck_fall) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7)
				shifter <= valid ? head.data : idle_byte;
			else
				// fill with ones behind the data
				shifter <= {shifter[6:0], 1'b1};
		end
	end

endmodule

`default_nettype wire

/* sd_reply_fifo.sv */
/*
 * Reply FIFO between decoder and transmitter.
 * Circular store of reply items; the decoder never pushes beyond its
 * credits so there is no full flag. Every pop hands one credit back
 * to the decoder one cycle later.
 */
`default_nettype none

module sd_reply_fifo import sd_card_pkg::*; (
	input  wire         buffer_dout_strobe,
	input  wire         io_ack,
	input  wire         push,
	input  reply_item_t push_item,
	input  wire         pop,
	output reply_item_t head,
	output logic        valid,
	output logic        credit_return
);

	typedef logic [$clog2(reply_fifo_depth)-1:0] ptr_t;

	reply_item_t mem [reply_fifo_depth];

	ptr_t    wr_ptr;
	ptr_t    rd_ptr;
	credit_t count;
	logic    do_pop;

	assign valid  = (count != '0);
	assign head   = mem[rd_ptr];
	// pop on empty is ignored
	assign do_pop = pop && valid;

	// storage
	always_ff @(posedge buffer_dout_strobe) begin
		if (push)
			mem[wr_ptr] <= push_item;
	end

	// pointers wrap naturally at the power of two depth
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + ptr_t'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + ptr_t'(1);
			// simultaneous push and pop keeps the count
			case ({push, do_pop})
				2'b10:   count <= count + credit_t'(1);
				2'b01:   count <= count - credit_t'(1);
				default: ;
			endcase
			credit_return <= do_pop;
		end
	end

endmodule

`default_nettype wire

/* sd_cmd_decoder.sv */
/*
 * Producer side of the card. Assembles SPI bytes, decodes six byte
 * commands and pushes reply items into the reply FIFO under credit
 * control. CMD17 requests a sector from the IO controller and streams
 * it back as token, 512 data bytes and two filler CRC bytes.
 */
`default_nettype none

module sd_cmd_decoder import sd_spi_pkg::*, sd_card_pkg::*; (
	input  wire         buffer_dout_strobe,
	input  wire         io_ack,
	input  wire         cs_active,
	input  wire         sck_rise,
	input  wire         sdi_bit,
	input  wire         allow_sdhc,
	input  sd_byte_t    io_din,
	input  wire         io_din_strobe,
	input  wire         credit_return,
	output logic        push,
	output reply_item_t push_item,
	output logic        io_rd,
	output sd_lba_t     io_lba,
	output logic        io_din_ready
);

	dec_state_t state;

	// receive side
	logic [2:0] bit_cnt;
	logic [6:0] sbuf;
	logic       byte_done;
	sd_byte_t   rx_byte;

	// command and argument
	sd_cmd_t    cmd;
	sd_arg_t    arg;
	logic [2:0] arg_cnt;
	logic       prev_app;

	// reply set, R1 in the top byte
	logic [39:0] reply_buf;
	logic [2:0]  reply_left;
	logic        is_read;
	logic [7:0]  dec_r1;
	logic [31:0] dec_ext;
	logic [2:0]  dec_len;
	logic [31:0] ocr;

	// sector stream
	logic [8:0] sect_cnt;
	logic       data_done;
	logic       crc_second;

	credit_t credits;
	logic    has_credit;

	assign byte_done = cs_active && sck_rise && (bit_cnt == 3'd7);
	assign rx_byte   = {sbuf, sdi_bit};

	// bit 30 is the high capacity flag
	assign ocr = {1'b0, allow_sdhc, 30'd0};

	// sdhc cards take block numbers, others byte offsets
	assign io_lba = allow_sdhc ? arg : {9'd0, arg[31:9]};

	assign has_credit   = (credits != '0);
	assign io_din_ready = (state == dec_stream) && !data_done && has_credit;

	// bit assembly, MSB first
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			bit_cnt <= 3'd0;
		end else if (!cs_active) begin
			bit_cnt <= 3'd0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	always_ff @(posedge buffer_dout_strobe) begin
		if (cs_active && sck_rise)
			sbuf <= {sbuf[5:0], sdi_bit};
	end

	// reply set for the command just completed
	always_comb begin
		dec_r1  = r1_illegal;
		dec_ext = '0;
		dec_len = 3'd0;
		case (cmd)
			cmd_go_idle:      dec_r1 = r1_idle;
			cmd_send_op_cond: dec_r1 = r1_ready;
			cmd_send_if_cond: begin
				dec_r1  = r1_idle;
				dec_ext = if_cond_echo;
				dec_len = 3'd4;
			end
			// block length fixed
			cmd_set_blocklen: begin
				dec_r1 = (arg == sd_arg_t'(sector_bytes)) ? r1_ready : r1_param_err;
			end
			cmd_read_single:  dec_r1 = r1_ready;
			cmd_app_cmd:      dec_r1 = r1_idle;
			cmd_app_op_cond: begin
				if (prev_app)
					dec_r1 = r1_ready;
			end
			cmd_read_ocr: begin
				dec_r1  = r1_ready;
				dec_ext = ocr;
				dec_len = 3'd4;
			end
			default: ;
		endcase
	end

	// item selection per state
	always_comb begin
		push           = 1'b0;
		push_item.data = idle_byte;
		push_item.last = 1'b0;
		case (state)
			dec_reply: begin
				push           = has_credit;
				push_item.data = reply_buf[39:32];
				// read replies end after the CRC instead
				push_item.last = (reply_left == 3'd0) && !is_read;
			end
			dec_wait_io: begin
				push           = has_credit;
				push_item.data = data_token;
			end
			dec_stream: begin
				if (!data_done) begin
					push           = io_din_strobe && io_din_ready;
					push_item.data = io_din;
				end else begin
					push           = has_credit;
					push_item.last = crc_second;
				end
			end
			default: ;
		endcase
	end

	// spend one per push, regain one per pop
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			credits <= credit_t'(reply_fifo_depth);
		end else begin
			case ({push, credit_return})
				2'b10:   credits <= credits - credit_t'(1);
				2'b01:   credits <= credits + credit_t'(1);
				default: ;
			endcase
		end
	end

	// argument and reply payload
	always_ff @(posedge buffer_dout_strobe) begin
		if (state == dec_collect && byte_done) begin
			if (arg_cnt != 3'd4)
				arg <= {arg[23:0], rx_byte};
			else
				reply_buf <= {dec_r1, dec_ext};
		end else if (state == dec_reply && push) begin
			reply_buf <= {reply_buf[31:0], 8'h00};
		end
	end

	// main FSM
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			state      <= dec_idle;
			cmd        <= '0;
			prev_app   <= 1'b0;
			arg_cnt    <= 3'd0;
			reply_left <= 3'd0;
			is_read    <= 1'b0;
			io_rd      <= 1'b0;
			sect_cnt   <= 9'd0;
			data_done  <= 1'b0;
			crc_second <= 1'b0;
		end else begin
			case (state)
				dec_idle: begin
					// 01 prefix marks a command start
					if (byte_done && rx_byte[7:6] == 2'b01) begin
						prev_app <= (cmd == cmd_app_cmd);
						cmd      <= rx_byte;
						arg_cnt  <= 3'd0;
						state    <= dec_collect;
					end
				end
				dec_collect: begin
					if (byte_done) begin
						arg_cnt <= arg_cnt + 3'd1;
						// fifth byte after the command is the CRC, ignored
						if (arg_cnt == 3'd4) begin
							reply_left <= dec_len;
							is_read    <= (cmd == cmd_read_single);
							state      <= dec_reply;
						end
					end
				end
				dec_reply: begin
					if (push) begin
						reply_left <= reply_left - 3'd1;
						if (reply_left == 3'd0) begin
							if (is_read) begin
								io_rd <= 1'b1;
								state <= dec_wait_io;
							end else begin
								state <= dec_idle;
							end
						end
					end
				end
				// token goes in before the controller is let through
				dec_wait_io: begin
					if (push) begin
						sect_cnt   <= 9'd0;
						data_done  <= 1'b0;
						crc_second <= 1'b0;
						state      <= dec_stream;
					end
				end
				dec_stream: begin
					if (push && !data_done) begin
						io_rd    <= 1'b0;
						sect_cnt <= sect_cnt + 9'd1;
						if (sect_cnt == 9'(sector_bytes - 1))
							data_done <= 1'b1;
					end else if (push) begin
						crc_second <= 1'b1;
						if (crc_second)
							state <= dec_idle;
					end
				end
				default: state <= dec_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* sd_card_pkg.sv */
/*
 * Card side definitions of the SD card emulation.
 * Byte and block address types, the reply item that travels from the
 * decoder through the reply FIFO to the transmitter, the FIFO depth
 * with its credit count, and the decoder state encoding.
 */
`default_nettype none

package sd_card_pkg;

	typedef logic [7:0] sd_byte_t;

	// block address towards the IO controller
	typedef logic [31:0] sd_lba_t;

	// one reply byte, last set on the final byte of a reply
	typedef struct packed {
		sd_byte_t data;
		logic     last;
	} reply_item_t;

	// reply FIFO size in items
	localparam int reply_fifo_depth = 16;

	// credits 0 .. reply_fifo_depth
	typedef logic [4:0] credit_t;

	// only 512 byte blocks are supported
	localparam int sector_bytes = 512;

	// decoder FSM
	typedef enum logic [2:0] {
		dec_idle,
		dec_collect,
		dec_reply,
		dec_wait_io,
		dec_stream
	} dec_state_t;

endpackage

`default_nettype wire

/* sd_spi_pkg.sv */
/*
 * SPI side definitions of the SD card emulation.
 * Command byte and argument types, the command codes that the card
 * decodes, R1 reply values and the data tokens seen on the wire.
 * Imported by the command decoder and the SPI transmitter.
 */
`default_nettype none

package sd_spi_pkg;

	// command byte as received, 01 start prefix included
	typedef logic [7:0] sd_cmd_t;

	// 32 bit argument, MSB first on the wire
	typedef logic [31:0] sd_arg_t;

	// basic command set
	localparam sd_cmd_t cmd_go_idle      = 8'h40;
	localparam sd_cmd_t cmd_send_op_cond = 8'h41;
	localparam sd_cmd_t cmd_send_if_cond = 8'h48;
	localparam sd_cmd_t cmd_set_blocklen = 8'h50;
	localparam sd_cmd_t cmd_read_single  = 8'h51;

	// application commands, ACMD41 only valid right after CMD55
	localparam sd_cmd_t cmd_app_cmd      = 8'h77;
	localparam sd_cmd_t cmd_app_op_cond  = 8'h69;

	// OCR readout
	localparam sd_cmd_t cmd_read_ocr     = 8'h7a;

	// R1 reply values
	localparam logic [7:0] r1_ready     = 8'h00;
	localparam logic [7:0] r1_idle      = 8'h01;
	localparam logic [7:0] r1_illegal   = 8'h04;
	localparam logic [7:0] r1_param_err = 8'h40;

	// CMD8 echo, voltage accepted plus check pattern
	localparam logic [31:0] if_cond_echo = 32'h0000_01aa;

	// start of a data block
	localparam logic [7:0] data_token = 8'hfe;

	// line idle, also used as dummy CRC
	localparam logic [7:0] idle_byte = 8'hff;

endpackage

`default_nettype wire
